//--- Makefile
VERILATOR ?= verilator
TOP       ?= alu_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

SRCS := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BUILD_DIR)/$(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/alu_sva.sv
`timescale 1ns/100ps

module alu_sva
  import alu_pkg::*;
(
  input logic      clk_core,
  input logic      reset,
  input logic      in_req,
  input logic      in_ack,
  input logic      out_req,
  input logic      out_ack,
  input alu_resp_t out_resp
);

  // number of property failures seen so far
  int unsigned fail_count = 0;

  // the receiver may only acknowledge a request that is actually present
  assert property (@(posedge clk_core) disable iff (reset)
    $rose(in_ack) |-> $past(in_req))
    else begin
      fail_count = fail_count + 1;
      $error("in_ack rose while in_req was low");
    end

  // once raised, out_req is held until the consumer answers
  assert property (@(posedge clk_core) disable iff (reset)
    out_req && !out_ack |=> out_req)
    else begin
      fail_count = fail_count + 1;
      $error("out_req dropped before out_ack");
    end

  // the result word must not move under an open request
  assert property (@(posedge clk_core) disable iff (reset)
    out_req |-> $stable(out_resp))
    else begin
      fail_count = fail_count + 1;
      $error("out_resp changed while out_req was high");
    end

  // both handshake outputs come out of reset low
  assert property (@(posedge clk_core)
    reset |=> !in_ack && !out_req)
    else begin
      fail_count = fail_count + 1;
      $error("handshake output high after reset");
    end

endmodule

bind alu_top alu_sva u_sva (
  .clk_core(clk_core),
  .reset   (reset),
  .in_req  (in_req),
  .in_ack  (in_ack),
  .out_req (out_req),
  .out_ack (out_ack),
  .out_resp(out_resp)
);

//--- bench/alu_tb.sv
`timescale 1ns/100ps

`include "alu_cfg.svh"

module alu_tb
  import alu_pkg::*;
();

  localparam int NUM_OPS        = 400;
  localparam int TIMEOUT_CYCLES = 500;

  logic        clk_core;
  logic        reset;
  logic        in_req;
  alu_req_t    in_op;
  logic        in_ack;
  logic        out_req;
  logic        out_ack;
  alu_resp_t   out_resp;

  // the driver queues expected results in issue order and the responder drains them
  alu_resp_t   expected_q[$];
  // idle cycles before each out_ack, one entry per operation
  int          ack_gap[NUM_OPS];
  logic [31:0] lcg_state;

  alu_top DUT (
    .clk_core(clk_core),
    .reset   (reset),
    .in_req  (in_req),
    .in_op   (in_op),
    .in_ack  (in_ack),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_resp(out_resp)
  );

  initial begin
    clk_core = 1'b0;
    forever #20 clk_core = ~clk_core;
  end

  // the constants come from numerical recipes and only the upper half of the
  // state is random enough to use
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // reference behavior written from the instruction rules of the ISA
  function automatic alu_resp_t expected_response(logic [3:0] op, word a, word b,
                                                  logic [3:0] tag);
    alu_resp_t resp;
    resp.tag    = tag;
    resp.trap   = 1'b0;
    resp.result = '0;
    case (op)
      4'd0:    resp.result = a + b;
      4'd1:    resp.result = a - b;
      4'd2:    resp.result = a << b[4:0];
      4'd3:    resp.result = a >> b[4:0];
      4'd4:    resp.result = word'($signed(a) >>> b[4:0]);
      4'd5:    resp.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      4'd6:    resp.result = (a < b) ? 32'd1 : 32'd0;
      default: resp.trap   = 1'b1;
    endcase
    return resp;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, expected);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Test failures found");
    $fatal(1);
  endtask

  // both waits poll on the falling edge, where DUT outputs are settled
  task automatic wait_in_ack(input logic level);
    int cycles;
    cycles = 0;
    while (in_ack !== level) begin
      @(negedge clk_core);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) report_timeout("input handshake stalled waiting on in_ack");
    end
  endtask

  task automatic wait_out_req(input logic level);
    int cycles;
    cycles = 0;
    while (out_req !== level) begin
      @(negedge clk_core);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) report_timeout("output handshake stalled waiting on out_req");
    end
  endtask

  task automatic draw_ack_gaps();
    logic [31:0] r;
    for (int i = 0; i < NUM_OPS; i++) begin
      // zero cycles three times in eight, otherwise one to five cycles
      r          = next_random();
      ack_gap[i] = int'(r[20:18]);
      if (ack_gap[i] > 5) ack_gap[i] = 0;
    end
  endtask

  task automatic drive_ops();
    logic [31:0] r;
    logic [31:0] s;
    logic [3:0]  op;
    word         a;
    word         b;
    int          gap;
    for (int i = 0; i < NUM_OPS; i++) begin
      // a gap of zero more often than not, so back-to-back requests are common
      r   = next_random();
      gap = int'(r[18:16]);
      if (gap > 3) gap = 0;
      repeat (gap) @(negedge clk_core);
      // about one opcode in eight falls into the illegal range 7 to 15
      r = next_random();
      if (r[31:29] == 3'd0) op = 4'd7 + (r[27:24] % 4'd9);
      else op = r[27:24] % 4'd7;
      r = next_random();
      s = next_random();
      a = {r[31:16], s[31:16]};
      r = next_random();
      s = next_random();
      b = {r[31:16], s[31:16]};
      // force equal operands and zero shift counts now and then
      r = next_random();
      case (r[31:29])
        3'd0:    b = a;
        3'd1:    b[4:0] = 5'd0;
        default: ;
      endcase
      in_op.op   = alu_op_e'(op);
      in_op.src1 = a;
      in_op.src2 = b;
      in_op.tag  = i[3:0];
      expected_q.push_back(expected_response(op, a, b, i[3:0]));
      in_req = 1'b1;
      wait_in_ack(1'b1);
      in_req = 1'b0;
      wait_in_ack(1'b0);
    end
  endtask

  task automatic collect_results();
    alu_resp_t   exp;
    for (int i = 0; i < NUM_OPS; i++) begin
      wait_out_req(1'b1);
      repeat (ack_gap[i]) @(negedge clk_core);
      if (expected_q.size() == 0) begin
        $display("result delivered at %0t with no operation outstanding", $time);
        $display("Test failures found");
        $fatal(1);
      end
      exp = expected_q.pop_front();
      check_value("out_resp.tag", 32'(out_resp.tag), 32'(exp.tag));
      check_value("out_resp.result", out_resp.result, exp.result);
      check_value("out_resp.trap", 32'(out_resp.trap), 32'(exp.trap));
      out_ack = 1'b1;
      wait_out_req(1'b0);
      out_ack = 1'b0;
    end
  endtask

  initial begin
    lcg_state = 32'd59415;
    reset     = 1'b1;
    in_req    = 1'b0;
    in_op     = '0;
    out_ack   = 1'b0;
    draw_ack_gaps();
    repeat (3) @(posedge clk_core);
    @(negedge clk_core);
    reset = 1'b0;
    check_value("in_ack", 32'(in_ack), 32'd0);
    check_value("out_req", 32'(out_req), 32'd0);
    fork
      drive_ops();
      collect_results();
    join
    // nothing extra may come out once every operation has been answered
    repeat (8) @(negedge clk_core);
    check_value("out_req", 32'(out_req), 32'd0);
    if (DUT.u_sva.fail_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("%0d handshake assertions failed during the run", DUT.u_sva.fail_count);
      $display("Test failures found");
      $fatal(1);
    end
  end

endmodule

//--- compile.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/alu_issue.sv
verilog/alu_setup.sv
verilog/alu_shift_add.sv
verilog/alu_commit.sv
verilog/alu_top.sv
bench/alu_sva.sv
bench/alu_tb.sv

//--- verilog/alu_cfg.svh
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// width of one data word as seen by the execute unit
`define ALU_XLEN 32

// the tag travels with each operation so that the consumer can match
// results against the order in which it issued them
`define ALU_TAG_W 4

// opcode field width, room for sixteen codes of which seven are legal
`define ALU_OP_W 4

// the shifter count needs one bit more than log2 of the word width,
// since a left shift by zero turns into a right shift by a full word
`define ALU_SHIFT_W 6

// the adder runs one bit wider than the word so that its top bit can
// serve as the borrow of a subtraction
`define ALU_ADDER_W 33

`endif

//--- verilog/alu_commit.sv
`timescale 1ns/100ps

`include "alu_cfg.svh"

module alu_commit
  import alu_pkg::*;
(
  input  logic      clk_core,
  input  logic      reset,

  // result from the shift/add stage
  input  logic      sa_valid,
  input  alu_resp_t sa_resp,

  // holds the whole pipeline while the slot is full
  output logic      stall,

  // four-phase output handshake
  output logic      out_req,
  input  logic      out_ack,
  output alu_resp_t out_resp
);

  commit_state_e state;
  logic          load;

  // the slot is busy from capture until the sender sees out_ack return low
  assign stall = (state != IDLE);

  // a result can only be loaded while nothing is held, which is the same
  // as stall being low
  assign load = sa_valid && !stall;

  always_ff @(posedge clk_core) begin
    if (reset) begin
      state   <= IDLE;
      out_req <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (load) state <= REQ;
        end
        REQ: begin
          // out_req goes up one cycle after capture, with out_resp
          // already stable behind it
          if (!out_req) begin
            out_req <= 1'b1;
          end else if (out_ack) begin
            out_req <= 1'b0;
            state   <= WAIT_LOW;
          end
        end
        WAIT_LOW: begin
          // the slot is freed only after the receiver completes
          // the return to zero
          if (!out_ack) state <= IDLE;
        end
        default: begin
          state   <= IDLE;
          out_req <= 1'b0;
        end
      endcase
    end
  end

  // result slot, held unchanged for as long as the handshake runs
  always_ff @(posedge clk_core) begin
    if (load) out_resp <= sa_resp;
  end

endmodule

//--- verilog/alu_issue.sv
`timescale 1ns/100ps

`include "alu_cfg.svh"

module alu_issue
  import alu_pkg::*;
(
  input  logic     clk_core,
  input  logic     reset,

  // four-phase input handshake
  input  logic     in_req,
  input  alu_req_t in_op,
  output logic     in_ack,

  // back-pressure from the output side
  input  logic     stall,

  // holding slot offered to the setup stage
  output logic     iss_valid,
  output alu_req_t iss_req
);

  logic     slot_valid;
  alu_req_t slot_op;
  logic     take;
  logic     pass_on;

  // a new request is taken only while in_ack is low, so one request that
  // is still held high by the sender is never captured a second time
  assign take = in_req && !in_ack && !slot_valid;

  // the slot empties on any edge where setup is free to load it
  assign pass_on = slot_valid && !stall;

  always_ff @(posedge clk_core) begin
    if (reset) begin
      slot_valid <= 1'b0;
      in_ack     <= 1'b0;
    end else begin
      if (take) begin
        slot_valid <= 1'b1;
        in_ack     <= 1'b1;
      end else begin
        // return to zero once the sender has dropped its request
        if (in_ack && !in_req) in_ack <= 1'b0;
        if (pass_on) slot_valid <= 1'b0;
      end
    end
  end

  // the operation itself only needs to be written when it is taken
  always_ff @(posedge clk_core) begin
    if (take) slot_op <= in_op;
  end

  assign iss_valid = slot_valid;
  assign iss_req   = slot_op;

endmodule

//--- verilog/alu_pkg.sv
`include "alu_cfg.svh"

package alu_pkg;

  // plain data word
  typedef logic [`ALU_XLEN-1:0] word;

  // adder operand, one bit wider than a word so the carry out can be kept
  typedef logic [`ALU_ADDER_W-1:0] adder_in;

  // right shift amount in the range 0 to 32
  typedef logic [`ALU_SHIFT_W-1:0] shift_cnt;

  // opcodes accepted by the unit, every code from 7 upward is illegal
  typedef enum logic [`ALU_OP_W-1:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6
  } alu_op_e;

  // picks which datapath drives the result word
  typedef enum logic {
    ALU_OUT_ADDER = 1'b0,
    ALU_OUT_SHIFT = 1'b1
  } alu_out_sel_e;

  // one operation as presented on the input handshake
  typedef struct packed {
    alu_op_e                op;
    word                    src1;
    word                    src2;
    logic [`ALU_TAG_W-1:0]  tag;
  } alu_req_t;

  // control bits that ride along with the operands from setup to shift/add
  typedef struct packed {
    alu_out_sel_e           out_select;
    logic                   compare;
    logic                   illegal;
    logic [`ALU_TAG_W-1:0]  tag;
  } alu_data_t;

  // one finished result as offered on the output handshake
  typedef struct packed {
    logic [`ALU_TAG_W-1:0]  tag;
    word                    result;
    logic                   trap;
  } alu_resp_t;

  // states of the output side sender
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    REQ      = 2'd1,
    WAIT_LOW = 2'd2
  } commit_state_e;

endpackage

//--- verilog/alu_setup.sv
`timescale 1ns/100ps

`include "alu_cfg.svh"

module alu_setup
  import alu_pkg::*;
(
  input  logic      clk_core,
  input  logic      reset,
  input  logic      stall,

  // operation from the issue slot
  input  logic      iss_valid,
  input  alu_req_t  iss_req,

  // registered operands and control for the shift/add stage
  output logic      setup_valid,
  output alu_data_t setup_data,
  output word       shift_lo,
  output word       shift_hi,
  output shift_cnt  shift_count,
  output adder_in   adder_a,
  output adder_in   adder_b
);

  alu_data_t data_d;
  word       lo_d;
  word       hi_d;
  shift_cnt  count_d;
  adder_in   a_d;
  adder_in   b_d;
  word       op_a;
  word       op_b;
  logic      negate;

  always_comb begin
    // by default the adder sees plain src1 + src2 and the shifter a right
    // logical shift, each opcode then only overrides what differs
    data_d.out_select = ALU_OUT_ADDER;
    data_d.compare    = 1'b0;
    data_d.illegal    = 1'b0;
    data_d.tag        = iss_req.tag;
    op_a              = iss_req.src1;
    op_b              = iss_req.src2;
    negate            = 1'b0;
    lo_d              = iss_req.src1;
    hi_d              = '0;
    count_d           = {1'b0, iss_req.src2[4:0]};

    case (iss_req.op)
      ALU_ADD: begin
      end
      ALU_SUB: negate = 1'b1;
      ALU_SRL: data_d.out_select = ALU_OUT_SHIFT;
      ALU_SRA: begin
        data_d.out_select = ALU_OUT_SHIFT;
        // upper half filled with copies of the sign bit
        hi_d = {`ALU_XLEN{iss_req.src1[`ALU_XLEN-1]}};
      end
      ALU_SLL: begin
        // a left shift by n is the low word of {src1, 0} shifted right
        // by 32 - n, which also covers n = 0 with a full word shift
        data_d.out_select = ALU_OUT_SHIFT;
        hi_d    = iss_req.src1;
        lo_d    = '0;
        count_d = 6'd32 - {1'b0, iss_req.src2[4:0]};
      end
      ALU_SLTU: begin
        negate         = 1'b1;
        data_d.compare = 1'b1;
      end
      ALU_SLT: begin
        // flipping both sign bits maps signed order onto unsigned order
        negate         = 1'b1;
        data_d.compare = 1'b1;
        op_a = iss_req.src1 ^ {1'b1, {(`ALU_XLEN-1){1'b0}}};
        op_b = iss_req.src2 ^ {1'b1, {(`ALU_XLEN-1){1'b0}}};
      end
      default: begin
        data_d.illegal = 1'b1;
        op_a           = '0;
        op_b           = '0;
      end
    endcase

    // operands are zero extended to 33 bits and src2 is negated at that
    // width, so bit 32 of the sum is set exactly when src1 < src2
    a_d = {1'b0, op_a};
    b_d = negate ? (~{1'b0, op_b} + 33'd1) : {1'b0, op_b};
  end

  always_ff @(posedge clk_core) begin
    if (reset) begin
      setup_valid <= 1'b0;
    end else if (!stall) begin
      setup_valid <= iss_valid;
    end
  end

  // operand registers advance together with the valid bit
  always_ff @(posedge clk_core) begin
    if (!stall) begin
      setup_data  <= data_d;
      shift_lo    <= lo_d;
      shift_hi    <= hi_d;
      shift_count <= count_d;
      adder_a     <= a_d;
      adder_b     <= b_d;
    end
  end

endmodule

//--- verilog/alu_shift_add.sv
`timescale 1ns/100ps

`include "alu_cfg.svh"

module alu_shift_add
  import alu_pkg::*;
(
  input  logic      clk_core,
  input  logic      reset,
  input  logic      stall,

  // operands prepared by the setup stage
  input  logic      setup_valid,
  input  alu_data_t setup_data,
  input  word       shift_lo,
  input  word       shift_hi,
  input  shift_cnt  shift_count,
  input  adder_in   adder_a,
  input  adder_in   adder_b,

  // registered result for the output side
  output logic      sa_valid,
  output alu_resp_t sa_resp
);

  word  shift_q;
  word  adder_sum;
  word  adder_q;
  word  alu_q;
  logic adder_carry;

  // every shift is a right shift of the 64-bit pair {hi, lo}, and only the
  // low word of that is ever wanted
  assign shift_q = word'({shift_hi, shift_lo} >> shift_count);

  always_comb begin
    // the one 33-bit adder serves add, sub and both compares
    {adder_carry, adder_sum} = adder_a + adder_b;

    // for compares the setup stage already negated src2, so bit 32 of the
    // sum is the less-than flag and becomes the whole result
    if (setup_data.compare) begin
      adder_q = {{(`ALU_XLEN-1){1'b0}}, adder_carry};
    end else begin
      adder_q = adder_sum;
    end

    case (setup_data.out_select)
      ALU_OUT_SHIFT: alu_q = shift_q;
      default:       alu_q = adder_q;
    endcase
  end

  always_ff @(posedge clk_core) begin
    if (reset) begin
      sa_valid <= 1'b0;
    end else if (!stall) begin
      sa_valid <= setup_valid;
    end
  end

  // an illegal op reaches here with zero adder operands, so its result
  // word is already zero and only the trap bit has to be carried
  always_ff @(posedge clk_core) begin
    if (!stall) begin
      sa_resp.tag    <= setup_data.tag;
      sa_resp.result <= alu_q;
      sa_resp.trap   <= setup_data.illegal;
    end
  end

endmodule

//--- verilog/alu_top.sv
`timescale 1ns/100ps

`include "alu_cfg.svh"

module alu_top
  import alu_pkg::*;
(
  input  logic      clk_core,
  input  logic      reset,

  // operation input, four-phase req/ack
  input  logic      in_req,
  input  alu_req_t  in_op,
  output logic      in_ack,

  // result output, four-phase req/ack
  output logic      out_req,
  input  logic      out_ack,
  output alu_resp_t out_resp
);

  // back-pressure from the commit slot to every earlier stage
  logic      stall;

  // issue slot to setup
  logic      iss_valid;
  alu_req_t  iss_req;

  // setup to shift/add
  logic      setup_valid;
  alu_data_t setup_data;
  word       shift_lo;
  word       shift_hi;
  shift_cnt  shift_count;
  adder_in   adder_a;
  adder_in   adder_b;

  // shift/add to commit
  logic      sa_valid;
  alu_resp_t sa_resp;

  alu_issue u_issue (
    .clk_core (clk_core),
    .reset    (reset),
    .in_req   (in_req),
    .in_op    (in_op),
    .in_ack   (in_ack),
    .stall    (stall),
    .iss_valid(iss_valid),
    .iss_req  (iss_req)
  );

  alu_setup u_setup (
    .clk_core   (clk_core),
    .reset      (reset),
    .stall      (stall),
    .iss_valid  (iss_valid),
    .iss_req    (iss_req),
    .setup_valid(setup_valid),
    .setup_data (setup_data),
    .shift_lo   (shift_lo),
    .shift_hi   (shift_hi),
    .shift_count(shift_count),
    .adder_a    (adder_a),
    .adder_b    (adder_b)
  );

  alu_shift_add u_shift_add (
    .clk_core   (clk_core),
    .reset      (reset),
    .stall      (stall),
    .setup_valid(setup_valid),
    .setup_data (setup_data),
    .shift_lo   (shift_lo),
    .shift_hi   (shift_hi),
    .shift_count(shift_count),
    .adder_a    (adder_a),
    .adder_b    (adder_b),
    .sa_valid   (sa_valid),
    .sa_resp    (sa_resp)
  );

  alu_commit u_commit (
    .clk_core(clk_core),
    .reset   (reset),
    .sa_valid(sa_valid),
    .sa_resp (sa_resp),
    .stall   (stall),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_resp(out_resp)
  );

endmodule
